// File: design/offload_core.sv
`timescale 1ns/1ns
/* Sequential core with coprocessor offload */
module offload_core (
  input  logic                        clk_i,
  input  logic                        reset_i,
  output logic [xif_pkg::PMEM_AW-1:0] imem_addr_o,
  input  xif_pkg::instr_u             imem_rdata_i,
  output xif_pkg::x_issue_req_t       x_issue_req_o,
  input  xif_pkg::x_issue_resp_t      x_issue_resp_i,
  input  xif_pkg::x_result_t          x_result_i,
  output logic                        x_result_ready_o,
  output xif_pkg::commit_t            commit_o,
  output logic [31:0]                 tb_exit_o
);

  typedef enum logic [2:0] {
    FETCH,
    WAIT_MEM,
    EXEC,
    ISSUE,
    WAIT_RESULT,
    HALT
  } state_e;

  state_e                        state_q;
  logic [xif_pkg::XLEN-1:0]      pc_q;
  xif_pkg::instr_u               instr_q;
  logic [xif_pkg::ID_W-1:0]      id_cnt_q;
  logic                          wb_q;
  xif_pkg::commit_t              off_commit_q;

  logic [xif_pkg::XLEN-1:0]      regs [xif_pkg::NUM_REGS];
  logic [xif_pkg::XLEN-1:0]      rs1_val;
  logic [xif_pkg::XLEN-1:0]      rs2_val;
  logic [xif_pkg::XLEN-1:0]      imm_ext;
  logic [xif_pkg::XLEN-1:0]      local_wdata;

  logic                          is_addi;
  logic                          is_add;
  logic                          is_custom;
  logic                          is_exit;
  logic                          local_commit;
  logic                          issue_xfer;
  logic                          result_xfer;

  logic                          rf_we;
  logic [4:0]                    rf_waddr;
  logic [xif_pkg::XLEN-1:0]      rf_wdata;

  // Word address of the current pc
  assign imem_addr_o = pc_q[xif_pkg::PMEM_AW+1:2];

  // Register reads, x0 is hardwired to zero
  assign rs1_val = (instr_q.r_fmt.rs1 == 5'd0) ? '0 : regs[instr_q.r_fmt.rs1];
  assign rs2_val = (instr_q.r_fmt.rs2 == 5'd0) ? '0 : regs[instr_q.r_fmt.rs2];
  assign imm_ext = {{(xif_pkg::XLEN-12){instr_q.i_fmt.imm[11]}}, instr_q.i_fmt.imm};

  assign is_addi   = (instr_q.i_fmt.opcode == xif_pkg::OPC_OP_IMM) &&
                     (instr_q.i_fmt.funct3 == 3'b000);
  assign is_add    = (instr_q.r_fmt.opcode == xif_pkg::OPC_OP) &&
                     (instr_q.r_fmt.funct3 == 3'b000) &&
                     (instr_q.r_fmt.funct7 == 7'd0);
  assign is_custom = (instr_q.r_fmt.opcode == xif_pkg::OPC_CUSTOM0);
  assign is_exit   = (instr_q.r_fmt.opcode == xif_pkg::OPC_EXIT);

  assign local_wdata  = is_addi ? rs1_val + imm_ext : rs1_val + rs2_val;
  assign local_commit = (state_q == EXEC) && (is_addi || is_add);

  // Operands are read straight from the register file, which cannot change during ISSUE
  assign x_issue_req_o.valid = (state_q == ISSUE);
  assign x_issue_req_o.instr = instr_q;
  assign x_issue_req_o.rs1   = rs1_val;
  assign x_issue_req_o.rs2   = rs2_val;
  assign x_issue_req_o.id    = id_cnt_q;

  assign issue_xfer       = (state_q == ISSUE) && x_issue_resp_i.ready;
  assign x_result_ready_o = (state_q == WAIT_RESULT);
  assign result_xfer      = (state_q == WAIT_RESULT) && x_result_i.valid;

  // Single register file write port shared by local and offloaded results
  always_comb begin
    if (state_q == WAIT_RESULT) begin
      rf_we    = result_xfer && x_result_i.we && wb_q && (x_result_i.rd != 5'd0);
      rf_waddr = x_result_i.rd;
      rf_wdata = x_result_i.data;
    end else begin
      rf_we    = local_commit && (instr_q.r_fmt.rd != 5'd0);
      rf_waddr = instr_q.r_fmt.rd;
      rf_wdata = local_wdata;
    end
  end

  // Local work retires in EXEC, offloaded work one cycle after its result
  always_comb begin
    if (local_commit) begin
      commit_o.valid = 1'b1;
      commit_o.pc    = pc_q;
      commit_o.instr = instr_q;
      commit_o.rd    = instr_q.r_fmt.rd;
      commit_o.wdata = local_wdata;
      commit_o.we    = (instr_q.r_fmt.rd != 5'd0);
    end else begin
      commit_o = off_commit_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q            <= FETCH;
      pc_q               <= '0;
      id_cnt_q           <= '0;
      off_commit_q.valid <= 1'b0;
      tb_exit_o          <= '0;
    end else begin
      off_commit_q.valid <= result_xfer;
      // Capture the retirement record while pc still points at the offloaded instruction
      if (result_xfer) begin
        off_commit_q.pc    <= pc_q;
        off_commit_q.instr <= instr_q;
        off_commit_q.rd    <= x_result_i.rd;
        off_commit_q.wdata <= x_result_i.data;
        off_commit_q.we    <= x_result_i.we && wb_q && (x_result_i.rd != 5'd0);
      end
      case (state_q)
        FETCH:    state_q <= WAIT_MEM;
        WAIT_MEM: state_q <= EXEC;
        EXEC: begin
          if (is_addi || is_add) begin
            pc_q    <= pc_q + xif_pkg::XLEN'(4);
            state_q <= FETCH;
          end else if (is_custom) begin
            state_q <= ISSUE;
          end else if (is_exit) begin
            tb_exit_o <= {rs1_val[30:0], 1'b1};
            state_q   <= HALT;
          end else begin
            tb_exit_o <= {xif_pkg::EXIT_ILLEGAL, 1'b1};
            state_q   <= HALT;
          end
        end
        ISSUE: begin
          if (issue_xfer) begin
            id_cnt_q <= id_cnt_q + 1'b1;
            if (x_issue_resp_i.accept) begin
              state_q <= WAIT_RESULT;
            end else begin
              tb_exit_o <= {xif_pkg::EXIT_ILLEGAL, 1'b1};
              state_q   <= HALT;
            end
          end
        end
        WAIT_RESULT: begin
          if (result_xfer) begin
            pc_q    <= pc_q + xif_pkg::XLEN'(4);
            state_q <= FETCH;
          end
        end
        HALT:    state_q <= HALT;
        default: state_q <= FETCH;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == WAIT_MEM) begin
      instr_q <= imem_rdata_i;
    end
    if (issue_xfer) begin
      wb_q <= x_issue_resp_i.writeback;
    end
    if (rf_we) begin
      regs[rf_waddr] <= rf_wdata;
    end
  end

endmodule

// File: design/offload_top.sv
`timescale 1ns/1ns
/* Offload subsystem top */
module offload_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        prog_we_i,
  input  logic [xif_pkg::PMEM_AW-1:0] prog_addr_i,
  input  logic [xif_pkg::ILEN-1:0]    prog_data_i,
  output xif_pkg::commit_t            commit_o,
  output logic [31:0]                 tb_exit_o
);

  logic [xif_pkg::PMEM_AW-1:0] imem_addr;
  xif_pkg::instr_u             imem_rdata;
  xif_pkg::x_issue_req_t       x_issue_req;
  xif_pkg::x_issue_resp_t      x_issue_resp;
  xif_pkg::x_result_t          x_result;
  logic                        x_result_ready;

  prog_mem i_prog_mem (
    .clk_i   (clk_i),
    .we_i    (prog_we_i),
    .waddr_i (prog_addr_i),
    .wdata_i (prog_data_i),
    .raddr_i (imem_addr),
    .rdata_o (imem_rdata)
  );

  offload_core i_offload_core (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .imem_addr_o      (imem_addr),
    .imem_rdata_i     (imem_rdata),
    .x_issue_req_o    (x_issue_req),
    .x_issue_resp_i   (x_issue_resp),
    .x_result_i       (x_result),
    .x_result_ready_o (x_result_ready),
    .commit_o         (commit_o),
    .tb_exit_o        (tb_exit_o)
  );

  xif_coprocessor i_xif_coprocessor (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .x_issue_req_i    (x_issue_req),
    .x_issue_resp_o   (x_issue_resp),
    .x_result_o       (x_result),
    .x_result_ready_i (x_result_ready)
  );

endmodule

// File: design/prog_mem.sv
`timescale 1ns/1ns
/* Program memory */
module prog_mem (
  input  logic                        clk_i,
  input  logic                        we_i,
  input  logic [xif_pkg::PMEM_AW-1:0] waddr_i,
  input  logic [xif_pkg::ILEN-1:0]    wdata_i,
  input  logic [xif_pkg::PMEM_AW-1:0] raddr_i,
  output xif_pkg::instr_u             rdata_o
);

  logic [xif_pkg::ILEN-1:0] mem [xif_pkg::PMEM_DEPTH];

  // Loader write port, used while the core sits in reset
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Registered read, data follows the address by one cycle
  always_ff @(posedge clk_i) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

// File: design/xif_coprocessor.sv
`timescale 1ns/1ns
/* CUSTOM-0 coprocessor */
module xif_coprocessor (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  xif_pkg::x_issue_req_t  x_issue_req_i,
  output xif_pkg::x_issue_resp_t x_issue_resp_o,
  output xif_pkg::x_result_t     x_result_o,
  input  logic                   x_result_ready_i
);

  localparam int CNT_W = $clog2(xif_pkg::XLEN);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_e;

  state_e                   state_q;
  logic [CNT_W-1:0]         cnt_q;
  logic [xif_pkg::ID_W-1:0] id_q;
  logic [4:0]               rd_q;
  logic [xif_pkg::XLEN-1:0] mcand_q;
  logic [xif_pkg::XLEN-1:0] mplier_q;
  logic [xif_pkg::XLEN-1:0] res_q;

  logic [2:0]               f3;
  logic                     supported;
  logic                     start;
  logic [xif_pkg::XLEN-1:0] popcnt;
  logic [xif_pkg::XLEN-1:0] rev;

  assign f3        = x_issue_req_i.instr.r_fmt.funct3;
  assign supported = (x_issue_req_i.instr.r_fmt.opcode == xif_pkg::OPC_CUSTOM0) &&
                     ((f3 == xif_pkg::F3_MUL) || (f3 == xif_pkg::F3_POPCNT) ||
                      (f3 == xif_pkg::F3_REV));

  // Only one instruction in flight, so the channel opens only when idle
  assign x_issue_resp_o.ready     = (state_q == IDLE);
  assign x_issue_resp_o.accept    = supported;
  assign x_issue_resp_o.writeback = supported;

  assign start = x_issue_req_i.valid && (state_q == IDLE) && supported;

  // Single-cycle operations on rs1
  always_comb begin
    popcnt = '0;
    for (int i = 0; i < xif_pkg::XLEN; i++) begin
      popcnt  = popcnt + xif_pkg::XLEN'(x_issue_req_i.rs1[i]);
      rev[i]  = x_issue_req_i.rs1[xif_pkg::XLEN-1-i];
    end
  end

  assign x_result_o.valid = (state_q == DONE);
  assign x_result_o.id    = id_q;
  assign x_result_o.rd    = rd_q;
  assign x_result_o.data  = res_q;
  assign x_result_o.we    = 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start) begin
            cnt_q   <= '0;
            state_q <= (f3 == xif_pkg::F3_MUL) ? BUSY : DONE;
          end
        end
        BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(xif_pkg::XLEN - 1)) begin
            state_q <= DONE;
          end
        end
        // Hold the result until the core takes it
        DONE: begin
          if (x_result_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // MUL accumulates into res_q, one multiplier bit per cycle
  always_ff @(posedge clk_i) begin
    if (start) begin
      id_q     <= x_issue_req_i.id;
      rd_q     <= x_issue_req_i.instr.r_fmt.rd;
      mcand_q  <= x_issue_req_i.rs1;
      mplier_q <= x_issue_req_i.rs2;
      case (f3)
        xif_pkg::F3_POPCNT: res_q <= popcnt;
        xif_pkg::F3_REV:    res_q <= rev;
        default:            res_q <= '0;
      endcase
    end else if (state_q == BUSY) begin
      if (mplier_q[0]) begin
        res_q <= res_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

endmodule

// File: design/xif_pkg.sv
/* Offload subsystem shared definitions */
package xif_pkg;

  // Data path and instruction widths
  localparam int XLEN       = 32;
  localparam int ILEN       = 32;
  localparam int NUM_REGS   = 32;

  // Program memory geometry, one word per entry
  localparam int PMEM_DEPTH = 64;
  localparam int PMEM_AW    = 6;

  // Width of the tag carried with each offloaded instruction
  localparam int ID_W       = 4;

  // Major opcodes understood by the core
  localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;
  // EXIT shares its encoding with SYSTEM
  localparam logic [6:0] OPC_EXIT    = 7'b1110011;

  // CUSTOM-0 functions the coprocessor implements
  localparam logic [2:0] F3_MUL    = 3'b000;
  localparam logic [2:0] F3_POPCNT = 3'b001;
  localparam logic [2:0] F3_REV    = 3'b010;

  // Exit code posted for an instruction nobody can execute
  localparam logic [30:0] EXIT_ILLEGAL = 31'h7FF;

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Register-immediate layout
  typedef struct packed {
    logic signed [11:0] imm;
    logic [4:0]         rs1;
    logic [2:0]         funct3;
    logic [4:0]         rd;
    logic [6:0]         opcode;
  } i_fmt_t;

  // One instruction word seen through either layout
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  // Core to coprocessor issue request
  typedef struct packed {
    logic            valid;
    instr_u          instr;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [ID_W-1:0] id;
  } x_issue_req_t;

  // Coprocessor answer in the same cycle as the request
  typedef struct packed {
    logic ready;
    logic accept;
    logic writeback;
  } x_issue_resp_t;

  // Coprocessor to core result
  typedef struct packed {
    logic            valid;
    logic [ID_W-1:0] id;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    logic            we;
  } x_result_t;

  // Retirement record, one per committed instruction
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] instr;
    logic [4:0]      rd;
    logic [XLEN-1:0] wdata;
    logic            we;
  } commit_t;

endpackage

// File: flist.f
design/xif_pkg.sv
design/prog_mem.sv
design/offload_core.sv
design/xif_coprocessor.sv
design/offload_top.sv
sim/offload_assert.sv
sim/offload_tb.sv

// File: sim/offload_assert.sv
`timescale 1ns/1ns
/* Issue and result handshake checks */
module offload_assert (
  input logic                   clk_i,
  input logic                   reset_i,
  input xif_pkg::x_issue_req_t  issue_req_i,
  input xif_pkg::x_issue_resp_t issue_resp_i,
  input xif_pkg::x_result_t     result_i,
  input logic                   result_ready_i
);

  logic [xif_pkg::ID_W-1:0] last_id_q;

  // Tag of the most recent accepted offload
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_id_q <= '0;
    end else if (issue_req_i.valid && issue_resp_i.ready && issue_resp_i.accept) begin
      last_id_q <= issue_req_i.id;
    end
  end

  issue_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_req_i.valid && !issue_resp_i.ready |=> issue_req_i.valid && $stable(issue_req_i))
    else $error("Issue request changed before it was taken");

  result_held: assert property (@(posedge clk_i) disable iff (reset_i)
    result_i.valid && !result_ready_i |=> result_i.valid && $stable(result_i))
    else $error("Result dropped or changed before it was taken");

  result_id: assert property (@(posedge clk_i) disable iff (reset_i)
    result_i.valid |-> result_i.id == last_id_q)
    else $error("Result id does not match the last accepted issue");

  refused_no_result: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_req_i.valid && issue_resp_i.ready && !issue_resp_i.accept |=> !result_i.valid)
    else $error("Result produced for a refused issue");

endmodule

bind xif_coprocessor offload_assert i_offload_assert (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .issue_req_i    (x_issue_req_i),
  .issue_resp_i   (x_issue_resp_o),
  .result_i       (x_result_o),
  .result_ready_i (x_result_ready_i)
);

// File: sim/offload_tb.sv
`timescale 1ns/1ns
/* Offload subsystem testbench */
module offload_tb;

  localparam int NUM_FIXED  = 6;
  localparam int NUM_RANDOM = 4;
  localparam int NUM_ROWS   = NUM_FIXED + NUM_RANDOM;
  localparam int ROW_CYCLES = 200;
  localparam int MAX_CYCLES = NUM_ROWS * ROW_CYCLES;

  // One table row, with the values the rules predict for it
  typedef struct packed {
    logic        custom;
    logic [2:0]  f3;
    logic [11:0] a;
    logic [11:0] b;
    logic        legal;
    logic [31:0] exp_res;
    logic [31:0] exp_exit;
  } test_row_t;

  logic                        clk;
  logic                        reset;
  logic                        prog_we;
  logic [xif_pkg::PMEM_AW-1:0] prog_addr;
  logic [xif_pkg::ILEN-1:0]    prog_data;
  xif_pkg::commit_t            commit;
  logic [31:0]                 tb_exit;

  test_row_t test_rows[$];
  int        seed      = 32'h83234cda;
  int        cycle_cnt = 0;
  int        pass_cnt  = 0;
  int        fail_cnt  = 0;

  offload_top i_offload_top (
    .clk_i       (clk),
    .reset_i     (reset),
    .prog_we_i   (prog_we),
    .prog_addr_i (prog_addr),
    .prog_data_i (prog_data),
    .commit_o    (commit),
    .tb_exit_o   (tb_exit)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Global watchdog, sized from the number of table rows
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Simulation timed out after %0d cycles without an exit word", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // Clears the lowest set bit until nothing is left
  function automatic logic [31:0] count_ones(input logic [31:0] v);
    logic [31:0] n;
    n = '0;
    while (v != 0) begin
      v = v & (v - 1);
      n = n + 1;
    end
    return n;
  endfunction

  function automatic logic [31:0] reverse_bits(input logic [31:0] v);
    logic [31:0] r;
    r = '0;
    repeat (32) begin
      r = {r[30:0], v[0]};
      v = v >> 1;
    end
    return r;
  endfunction

  task automatic add_row(input logic custom, input logic [2:0] f3,
                         input logic [11:0] a, input logic [11:0] b);
    test_row_t row;
    row.custom  = custom;
    row.f3      = f3;
    row.a       = a;
    row.b       = b;
    row.legal   = !custom || (f3 == xif_pkg::F3_MUL) ||
                  (f3 == xif_pkg::F3_POPCNT) || (f3 == xif_pkg::F3_REV);
    row.exp_res = '0;
    if (!custom) begin
      row.exp_res = sext12(a) + sext12(b);
    end else if (f3 == xif_pkg::F3_MUL) begin
      row.exp_res = sext12(a) * sext12(b);
    end else if (f3 == xif_pkg::F3_POPCNT) begin
      row.exp_res = count_ones(sext12(a));
    end else if (f3 == xif_pkg::F3_REV) begin
      row.exp_res = reverse_bits(sext12(a));
    end
    row.exp_exit = row.legal ? {row.exp_res[30:0], 1'b1} : {xif_pkg::EXIT_ILLEGAL, 1'b1};
    test_rows.push_back(row);
  endtask

  function automatic string row_name(input test_row_t row);
    if (!row.custom) return "ADD";
    case (row.f3)
      xif_pkg::F3_MUL:    return "MUL";
      xif_pkg::F3_POPCNT: return "POPCNT";
      xif_pkg::F3_REV:    return "REV";
      default:            return $sformatf("CUSTOM f3=%0d", row.f3);
    endcase
  endfunction

  // Program: addi x1,a / addi x2,b / op x3,x1,x2 / exit x3
  function automatic logic [31:0] program_word(input test_row_t row, input int idx);
    logic [2:0] f3;
    logic [6:0] opc;
    f3  = row.custom ? row.f3 : 3'b000;
    opc = row.custom ? xif_pkg::OPC_CUSTOM0 : xif_pkg::OPC_OP;
    case (idx)
      0:       return {row.a, 5'd0, 3'b000, 5'd1, xif_pkg::OPC_OP_IMM};
      1:       return {row.b, 5'd0, 3'b000, 5'd2, xif_pkg::OPC_OP_IMM};
      2:       return {7'd0, 5'd2, 5'd1, f3, 5'd3, opc};
      default: return {12'd0, 5'd3, 3'b000, 5'd0, xif_pkg::OPC_EXIT};
    endcase
  endfunction

  task automatic load_program(input test_row_t row);
    for (int i = 0; i < 4; i++) begin
      prog_we   = 1'b1;
      prog_addr = xif_pkg::PMEM_AW'(i);
      prog_data = program_word(row, i);
      @(posedge clk);
      #2;
    end
    prog_we = 1'b0;
  endtask

  task automatic run_row(input int idx);
    test_row_t   row;
    int          n_commit;
    int          n_exp;
    int          errs;
    logic [31:0] exp_data;
    logic [31:0] exp_instr;
    row      = test_rows[idx];
    n_commit = 0;
    errs     = 0;
    n_exp    = row.legal ? 3 : 2;
    @(posedge clk);
    #2;
    reset = 1'b1;
    load_program(row);
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    while (!tb_exit[0]) begin
      @(negedge clk);
      if (commit.valid) begin
        exp_data = (n_commit == 0) ? sext12(row.a) :
                   (n_commit == 1) ? sext12(row.b) : row.exp_res;
        exp_instr = program_word(row, n_commit);
        if (n_commit >= n_exp) begin
          $display("Error at %0t: row %0d unexpected commit at pc %h", $time, idx, commit.pc);
          errs++;
        end else if (commit.pc != 32'(n_commit * 4) || commit.instr != exp_instr ||
                     commit.rd != 5'(n_commit + 1) || commit.wdata != exp_data ||
                     !commit.we) begin
          // Fields are pc, instr, rd and data
          $display("Error at %0t: row %0d commit %h %h %0d %h, expected %h %h %0d %h",
                   $time, idx, commit.pc, commit.instr, commit.rd, commit.wdata,
                   32'(n_commit * 4), exp_instr, n_commit + 1, exp_data);
          errs++;
        end
        n_commit++;
      end
    end
    if (n_commit != n_exp) begin
      $display("Error at %0t: row %0d saw %0d commits, expected %0d", $time, idx, n_commit, n_exp);
      errs++;
    end
    if (tb_exit != row.exp_exit) begin
      $display("Error at %0t: row %0d exit word %h, expected %h", $time, idx, tb_exit, row.exp_exit);
      errs++;
    end
    if (errs == 0) pass_cnt++;
    else fail_cnt++;
    $display("Row %0d %s a=%0d b=%0d: %s", idx, row_name(row), $signed(row.a), $signed(row.b),
             (errs == 0) ? "ok" : "failed");
  endtask

  initial begin
    logic [31:0] r;
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    add_row(1'b0, 3'b000, 12'd100, -12'sd7);
    add_row(1'b1, xif_pkg::F3_POPCNT, 12'h5A3, 12'd0);
    add_row(1'b1, xif_pkg::F3_REV, 12'h123, 12'd9);
    add_row(1'b1, xif_pkg::F3_MUL, 12'd123, -12'sd45);
    add_row(1'b1, xif_pkg::F3_MUL, 12'h800, 12'h7FF);
    add_row(1'b1, 3'b111, 12'd5, 12'd6);
    // Random MUL operands, both sign halves show up
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $random(seed);
      add_row(1'b1, xif_pkg::F3_MUL, r[11:0], r[27:16]);
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
